// File: hdl/kiwi_consts.svh
// Board constants for the shared-memory block.
// The shared RAM is 2 KB. The clock-enable ratio assumes a 24 MHz system clock.
`ifndef KIWI_CONSTS_SVH
`define KIWI_CONSTS_SVH

// Shared RAM address width, 2 KB array
`define KIWI_SHR_AW 11

// Download map
`define KIWI_MCU_START 16'h2000
`define KIWI_ID_ADDR 16'd4

// Title IDs found at the ID address
`define KIWI_ID_NO_MCU 8'h77
`define KIWI_ID_COLPROM 8'h0c

// cen6 ratio is N/M of the system clock
`define KIWI_CEN_N 1
`define KIWI_CEN_M 4

`endif

// File: hdl/kiwi_bus_pkg.sv
// CPU bus types shared by the two CPU ports and the shared RAM.
// Address width follows the shared RAM size from the constants header.
`include "kiwi_consts.svh"

package kiwi_bus_pkg;

    // Main CPU request toward the shared RAM
    typedef struct packed {
        logic                    cs;
        logic                    rnw;
        logic [`KIWI_SHR_AW-1:0] addr;
        logic [7:0]              din;
    } main_req_t;

    // Sub CPU request, same layout for now
    // Kept apart so that each side can grow on its own
    typedef struct packed {
        logic                    cs;
        logic                    rnw;
        logic [`KIWI_SHR_AW-1:0] addr;
        logic [7:0]              din;
    } sub_req_t;

    // Shared RAM answer to one port
    typedef struct packed {
        logic       ok;
        logic [7:0] dout;
    } ram_rsp_t;

endpackage

// File: hdl/kiwi_cfg_pkg.sv
// Download stream and title configuration types.
// The download address is the full 16-bit ROM load address.
package kiwi_cfg_pkg;

    // One download beat; prom_we marks PROM data within the stream
    typedef struct packed {
        logic        we;
        logic [15:0] addr;
        logic [7:0]  data;
        logic        prom_we;
    } dl_t;

    // Per-title hardware flags, latched from the ID byte
    typedef struct packed {
        logic mcu_en;
        logic colprom_en;
    } title_cfg_t;

endpackage

// File: hdl/kiwi_frac_cen.sv
// Clock enables derived from the 24 MHz system clock.
// cen6 pulses at N/M of clk; cen3 and cen1p5 are aligned subsets of cen6.
`include "kiwi_consts.svh"

module kiwi_frac_cen (
    input  logic clk,
    input  logic arst_n,
    output logic cen6,
    output logic cen3,
    output logic cen1p5
);

    localparam int ACC_W = $clog2(`KIWI_CEN_M + `KIWI_CEN_N) + 1;

    logic [ACC_W-1:0] acc_q;
    logic [ACC_W-1:0] acc_sum;
    logic             wrap;
    logic [1:0]       div_q;

    // Fractional step, wrap marks a cen6 cycle
    assign acc_sum = acc_q + ACC_W'(`KIWI_CEN_N);
    assign wrap    = acc_sum >= ACC_W'(`KIWI_CEN_M);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q  <= '0;
            div_q  <= 2'd0;
            cen6   <= 1'b0;
            cen3   <= 1'b0;
            cen1p5 <= 1'b0;
        end else begin
            if (wrap) begin
                acc_q <= acc_sum - ACC_W'(`KIWI_CEN_M);
            end else begin
                acc_q <= acc_sum;
            end
            cen6   <= wrap;
            // Slower strobes only ever fire on a cen6 cycle
            cen3   <= wrap && !div_q[0];
            cen1p5 <= wrap && (div_q == 2'd0);
            if (wrap) begin
                div_q <= div_q + 2'd1;
            end
        end
    end

endmodule

// File: hdl/kiwi_dl_decode.sv
// Title flags and PROM write steering from the ROM download stream.
// Flags are valid one clock after the ID byte is written; strobes are combinational.
`include "kiwi_consts.svh"

module kiwi_dl_decode (
    input  logic                    clk,
    input  logic                    arst_n,
    input  kiwi_cfg_pkg::dl_t        dl,
    output kiwi_cfg_pkg::title_cfg_t cfg,
    output logic                    colprom_we,
    output logic                    mcuprom_we
);

    logic id_we;

    assign id_we = dl.we && (dl.addr == `KIWI_ID_ADDR);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg.mcu_en     <= 1'b0;
            cfg.colprom_en <= 1'b0;
        end else if (id_we) begin
            // Every title has the MCU except the one with the no-MCU ID
            cfg.mcu_en     <= dl.data != `KIWI_ID_NO_MCU;
            cfg.colprom_en <= dl.data == `KIWI_ID_COLPROM;
        end
    end

    // Colour PROM sits in the first 1 KB of the PROM area
    assign colprom_we = dl.prom_we && (dl.addr[15:10] == 6'd0);

    // MCU program from its start address upward
    assign mcuprom_we = dl.prom_we && (dl.addr >= `KIWI_MCU_START);

endmodule

// File: hdl/kiwi_cpu_port.sv
// CPU side of the shared RAM with the cs/ok handshake.
// The CPU keeps cs and its fields stable until ok; ok holds until cs falls.
// Requests are only accepted on cen6 cycles.
module kiwi_cpu_port #(
    parameter type req_t = kiwi_bus_pkg::main_req_t
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   cen6,
    input  req_t                   req,
    output req_t                   pend,
    input  logic                   grant,
    input  kiwi_bus_pkg::ram_rsp_t rsp,
    output logic                   ok,
    output logic [7:0]             dout
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PEND,
        ST_DONE
    } state_t;

    state_t     state_q;
    req_t       held_q;
    logic       ok_q;
    logic [7:0] dout_q;
    logic       accept;

    assign accept = (state_q == ST_IDLE) && req.cs && cen6;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
            ok_q    <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (accept) state_q <= ST_PEND;
                ST_PEND: if (grant) state_q <= ST_DONE;
                ST_DONE: begin
                    // Answer arrives the clock after the grant
                    if (rsp.ok) begin
                        ok_q <= 1'b1;
                    end else if (ok_q && !req.cs) begin
                        ok_q    <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_q <= req;
        end
        if (state_q == ST_DONE && rsp.ok) begin
            dout_q <= rsp.dout;
        end
    end

    // Held request, cs now meaning pending
    always_comb begin
        pend    = held_q;
        pend.cs = (state_q == ST_PEND);
    end

    assign ok   = ok_q;
    assign dout = dout_q;

endmodule

// File: hdl/kiwi_shared_ram.sv
// Shared RAM between main and sub CPU ports, one grant per clock.
// Priority toggles round-robin; the answer comes one clock after the grant.
// With mshramen low, main reads give 8'hff and main writes are dropped.
`include "kiwi_consts.svh"

module kiwi_shared_ram (
    input  logic                    clk,
    input  logic                    arst_n,
    input  kiwi_bus_pkg::main_req_t main_pend,
    input  kiwi_bus_pkg::sub_req_t  sub_pend,
    input  logic                    mshramen,
    output logic                    main_grant,
    output logic                    sub_grant,
    output kiwi_bus_pkg::ram_rsp_t  main_rsp,
    output kiwi_bus_pkg::ram_rsp_t  sub_rsp
);

    logic [7:0]              mem [0:(1 << `KIWI_SHR_AW)-1];
    logic                    prio_q;
    logic [`KIWI_SHR_AW-1:0] sel_addr;
    logic [7:0]              sel_din;
    logic                    sel_we;
    logic [7:0]              rdata_q;
    logic                    main_ok_q;
    logic                    sub_ok_q;
    logic                    gate_q;

    // prio_q low favours main
    assign main_grant = main_pend.cs && (!sub_pend.cs || !prio_q);
    assign sub_grant  = sub_pend.cs && !main_grant;

    assign sel_addr = main_grant ? main_pend.addr : sub_pend.addr;
    assign sel_din  = main_grant ? main_pend.din : sub_pend.din;
    assign sel_we   = main_grant ? (!main_pend.rnw && mshramen)
                                 : (sub_grant && !sub_pend.rnw);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prio_q    <= 1'b0;
            main_ok_q <= 1'b0;
            sub_ok_q  <= 1'b0;
            gate_q    <= 1'b0;
        end else begin
            if (main_grant || sub_grant) begin
                prio_q <= main_grant;
            end
            main_ok_q <= main_grant;
            sub_ok_q  <= sub_grant;
            gate_q    <= main_grant && !mshramen;
        end
    end

    // Array access, read returns the old byte on a write
    always_ff @(posedge clk) begin
        if (sel_we) begin
            mem[sel_addr] <= sel_din;
        end
        rdata_q <= mem[sel_addr];
    end

    always_comb begin
        main_rsp.ok   = main_ok_q;
        main_rsp.dout = gate_q ? 8'hff : rdata_q;
        sub_rsp.ok    = sub_ok_q;
        sub_rsp.dout  = rdata_q;
    end

endmodule

// File: hdl/kiwi_shr_sys.sv
// Shared-memory and board-control block of the two-CPU arcade core.
// clk is the 24 MHz system clock. CPUs, video, sound and PROM memories are outside.
module kiwi_shr_sys (
    input  logic                     clk,
    input  logic                     arst_n,
    input  kiwi_bus_pkg::main_req_t  main_req,
    input  kiwi_bus_pkg::sub_req_t   sub_req,
    input  logic                     mshramen,
    input  kiwi_cfg_pkg::dl_t        dl,
    output logic                     main_ok,
    output logic [7:0]               main_dout,
    output logic                     sub_ok,
    output logic [7:0]               sub_dout,
    output kiwi_cfg_pkg::title_cfg_t cfg,
    output logic                     colprom_we,
    output logic                     mcuprom_we,
    output logic                     cen6,
    output logic                     cen3,
    output logic                     cen1p5
);

    kiwi_bus_pkg::main_req_t main_pend;
    kiwi_bus_pkg::sub_req_t  sub_pend;
    kiwi_bus_pkg::ram_rsp_t  main_rsp;
    kiwi_bus_pkg::ram_rsp_t  sub_rsp;
    logic                    main_grant;
    logic                    sub_grant;

    kiwi_frac_cen u_cen (
        .clk    (clk),
        .arst_n (arst_n),
        .cen6   (cen6),
        .cen3   (cen3),
        .cen1p5 (cen1p5)
    );

    kiwi_dl_decode u_dl (
        .clk        (clk),
        .arst_n     (arst_n),
        .dl         (dl),
        .cfg        (cfg),
        .colprom_we (colprom_we),
        .mcuprom_we (mcuprom_we)
    );

    kiwi_cpu_port #(.req_t(kiwi_bus_pkg::main_req_t)) u_main_port (
        .clk    (clk),
        .arst_n (arst_n),
        .cen6   (cen6),
        .req    (main_req),
        .pend   (main_pend),
        .grant  (main_grant),
        .rsp    (main_rsp),
        .ok     (main_ok),
        .dout   (main_dout)
    );

    // Both CPUs run off the same 6 MHz enable
    kiwi_cpu_port #(.req_t(kiwi_bus_pkg::sub_req_t)) u_sub_port (
        .clk    (clk),
        .arst_n (arst_n),
        .cen6   (cen6),
        .req    (sub_req),
        .pend   (sub_pend),
        .grant  (sub_grant),
        .rsp    (sub_rsp),
        .ok     (sub_ok),
        .dout   (sub_dout)
    );

    kiwi_shared_ram u_shr (
        .clk        (clk),
        .arst_n     (arst_n),
        .main_pend  (main_pend),
        .sub_pend   (sub_pend),
        .mshramen   (mshramen),
        .main_grant (main_grant),
        .sub_grant  (sub_grant),
        .main_rsp   (main_rsp),
        .sub_rsp    (sub_rsp)
    );

endmodule

// File: test/kiwi_shr_checker.sv
// Monitor for the shared-memory block with its own model of the shared RAM and title flags.
// Burst traffic must keep main and sub addresses apart, so grant order does not matter.
// Clock-enable pulses are counted over the first 64 clocks after reset.
`include "kiwi_consts.svh"

module kiwi_shr_checker (
    input logic                     clk,
    input logic                     arst_n,
    input kiwi_bus_pkg::main_req_t  main_req,
    input kiwi_bus_pkg::sub_req_t   sub_req,
    input logic                     mshramen,
    input kiwi_cfg_pkg::dl_t        dl,
    input logic                     main_ok,
    input logic [7:0]               main_dout,
    input logic                     sub_ok,
    input logic [7:0]               sub_dout,
    input kiwi_cfg_pkg::title_cfg_t cfg,
    input logic                     colprom_we,
    input logic                     mcuprom_we,
    input logic                     cen6,
    input logic                     cen3,
    input logic                     cen1p5
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] model [0:(1 << `KIWI_SHR_AW)-1];
    logic [1:0] flags_m;
    logic       main_ok_d;
    logic       sub_ok_d;
    logic       main_cs_d;
    logic       sub_cs_d;
    int         clk_cnt = 0;
    int         err_cnt = 0;
    int         chk_cnt = 0;
    int         cen6_cnt = 0;
    int         cen3_cnt = 0;
    int         cen1p5_cnt = 0;
    bit         cen_window_done = 1'b0;

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s exp %0h got %0h", name, exp, got);
        end
    endtask

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    // Requests complete on the first cycle ok is seen high
    always @(posedge clk) begin
        if (!arst_n) begin
            flags_m   = 2'b00;
            main_ok_d = 1'b0;
            sub_ok_d  = 1'b0;
            main_cs_d = 1'b0;
            sub_cs_d  = 1'b0;
        end else begin
            clk_cnt++;
            // ID byte sets MCU unless 8'h77 and colour PROM only for 8'h0c
            if (dl.we && dl.addr == 16'd4) begin
                flags_m = {dl.data != 8'h77, dl.data == 8'h0c};
            end
            if (main_ok && !main_ok_d) begin
                if (!main_req.cs) begin
                    report_failure("main ok rose while main cs was low");
                end else if (main_req.rnw) begin
                    check_value("main_dout", mshramen ? model[main_req.addr] : 8'hff, main_dout);
                end else if (mshramen) begin
                    model[main_req.addr] = main_req.din;
                end
            end
            if (sub_ok && !sub_ok_d) begin
                if (!sub_req.cs) begin
                    report_failure("sub ok rose while sub cs was low");
                end else if (sub_req.rnw) begin
                    check_value("sub_dout", model[sub_req.addr], sub_dout);
                end else begin
                    model[sub_req.addr] = sub_req.din;
                end
            end
            // ok has to be gone one cycle after cs falls
            if (main_ok && main_ok_d && !main_req.cs && !main_cs_d) begin
                report_failure("main ok still high a cycle after main cs fell");
            end
            if (sub_ok && sub_ok_d && !sub_req.cs && !sub_cs_d) begin
                report_failure("sub ok still high a cycle after sub cs fell");
            end
            main_ok_d = main_ok;
            sub_ok_d  = sub_ok;
            main_cs_d = main_req.cs;
            sub_cs_d  = sub_req.cs;
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            check_value("colprom_we", dl.prom_we && dl.addr < 16'h0400, colprom_we);
            check_value("mcuprom_we", dl.prom_we && dl.addr >= 16'h2000, mcuprom_we);
            check_value("cfg", flags_m, cfg);
            if (cen3 && !cen6) begin
                report_failure("cen3 pulsed without cen6");
            end
            if (cen1p5 && !cen6) begin
                report_failure("cen1p5 pulsed without cen6");
            end
            if (clk_cnt >= 1 && clk_cnt <= 64) begin
                if (cen6) cen6_cnt++;
                if (cen3) cen3_cnt++;
                if (cen1p5) cen1p5_cnt++;
                if (clk_cnt == 64) cen_window_done = 1'b1;
            end
        end
    end

endmodule

// File: test/kiwi_shr_tb.sv
// Testbench for the shared-memory block, driven from test/kiwi_shr_stimulus.txt.
// Run from the project root so that the stimulus path resolves.
`include "kiwi_consts.svh"

module kiwi_shr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_OPS = 32;

    logic                     clk = 1'b0;
    logic                     arst_n;
    kiwi_bus_pkg::main_req_t  main_req;
    kiwi_bus_pkg::sub_req_t   sub_req;
    logic                     mshramen;
    kiwi_cfg_pkg::dl_t        dl;
    logic                     main_ok;
    logic [7:0]               main_dout;
    logic                     sub_ok;
    logic [7:0]               sub_dout;
    kiwi_cfg_pkg::title_cfg_t cfg;
    logic                     colprom_we;
    logic                     mcuprom_we;
    logic                     cen6;
    logic                     cen3;
    logic                     cen1p5;

    logic [15:0]             stim [0:4*MAX_OPS-1];
    logic [31:0]             lfsr_q;
    logic [`KIWI_SHR_AW-1:0] burst_addr [0:1][0:7];
    logic [7:0]              burst_din [0:1][0:7];
    logic [1:0]              burst_gap [0:1][0:7];

    always #10 clk = ~clk;

    kiwi_shr_sys u_kiwi_shr_sys (.*);

    kiwi_shr_checker u_chk (.*);

    // Galois LFSR, one step per bit taken
    task automatic take_bits(input int n, output logic [15:0] val);
        int i;
        val = 16'h0000;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h80200003 : lfsr_q >> 1;
            val    = {val[14:0], lfsr_q[0]};
        end
    endtask

    // One cs/ok access on the main or the sub port
    task automatic bus_access(input bit is_sub, input bit rnw, input logic [15:0] addr,
                              input logic [7:0] din, output logic [7:0] rdata);
        int n;
        @(posedge clk);
        #1;
        if (is_sub) sub_req = {1'b1, rnw, addr[`KIWI_SHR_AW-1:0], din};
        else main_req = {1'b1, rnw, addr[`KIWI_SHR_AW-1:0], din};
        n = 0;
        while (!(is_sub ? sub_ok : main_ok) && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (!(is_sub ? sub_ok : main_ok)) begin
            if (is_sub) u_chk.report_failure("sub port gave no ok within 64 cycles");
            else u_chk.report_failure("main port gave no ok within 64 cycles");
        end
        rdata = is_sub ? sub_dout : main_dout;
        @(posedge clk);
        #1;
        if (is_sub) sub_req = '0;
        else main_req = '0;
        n = 0;
        while ((is_sub ? sub_ok : main_ok) && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (is_sub ? sub_ok : main_ok) begin
            u_chk.report_failure("ok stayed high after cs fell");
        end
    endtask

    // Write then read back each burst address, with random idle gaps
    task automatic run_side(input bit is_sub, input int pairs);
        logic [7:0] rd;
        int i;
        int g;
        for (i = 0; i < pairs; i++) begin
            for (g = 0; g < burst_gap[is_sub][i]; g++) begin
                @(posedge clk);
            end
            bus_access(is_sub, 1'b0, burst_addr[is_sub][i], burst_din[is_sub][i], rd);
            bus_access(is_sub, 1'b1, burst_addr[is_sub][i], 8'h00, rd);
            if (is_sub) u_chk.check_value("sub_dout", burst_din[is_sub][i], rd);
            else u_chk.check_value("main_dout", burst_din[is_sub][i], rd);
        end
    endtask

    task automatic collision_burst(input int pairs);
        logic [15:0] r;
        int s;
        int i;
        for (s = 0; s < 2; s++) begin
            for (i = 0; i < pairs && i < 8; i++) begin
                // Main keeps to the lower half of the RAM, sub to the upper half
                take_bits(`KIWI_SHR_AW - 1, r);
                burst_addr[s][i] = {s[0], r[`KIWI_SHR_AW-2:0]};
                take_bits(8, r);
                burst_din[s][i] = r[7:0];
                take_bits(2, r);
                burst_gap[s][i] = r[1:0];
            end
        end
        fork
            run_side(1'b0, pairs);
            run_side(1'b1, pairs);
        join
    endtask

    initial begin
        logic [15:0] op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] e;
        logic [7:0]  rd;
        int          idx;
        int          n;
        arst_n   = 1'b0;
        main_req = '0;
        sub_req  = '0;
        mshramen = 1'b1;
        dl       = '0;
        lfsr_q   = 32'hc4784f94;
        $readmemh("test/kiwi_shr_stimulus.txt", stim);
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (idx = 0; idx < MAX_OPS; idx++) begin
            op = stim[4*idx];
            a  = stim[4*idx+1];
            b  = stim[4*idx+2];
            e  = stim[4*idx+3];
            if ($isunknown(op)) begin
                u_chk.report_failure("stimulus file is missing or has no end line");
                break;
            end
            if (op == 16'h0000) break;
            case (op)
                16'h1: bus_access(1'b0, 1'b0, a, b[7:0], rd);
                16'h2: begin
                    bus_access(1'b0, 1'b1, a, 8'h00, rd);
                    u_chk.check_value("main_dout", e, rd);
                end
                16'h3: bus_access(1'b1, 1'b0, a, b[7:0], rd);
                16'h4: begin
                    bus_access(1'b1, 1'b1, a, 8'h00, rd);
                    u_chk.check_value("sub_dout", e, rd);
                end
                16'h5: begin
                    @(posedge clk);
                    #1;
                    dl = {1'b1, a, b[7:0], 1'b0};
                    @(posedge clk);
                    #1;
                    dl = '0;
                    @(negedge clk);
                    u_chk.check_value("cfg", e, cfg);
                end
                16'h6: begin
                    @(posedge clk);
                    #1;
                    dl = {1'b0, a, b[7:0], 1'b1};
                    @(negedge clk);
                    u_chk.check_value("colprom_we", e[1], colprom_we);
                    u_chk.check_value("mcuprom_we", e[0], mcuprom_we);
                    @(posedge clk);
                    #1;
                    dl = '0;
                end
                16'h7: begin
                    @(posedge clk);
                    #1;
                    mshramen = a[0];
                end
                16'h8: collision_burst(a);
                16'h9: begin
                    n = 0;
                    while (!u_chk.cen_window_done && n < 100) begin
                        @(negedge clk);
                        n++;
                    end
                    if (!u_chk.cen_window_done) begin
                        u_chk.report_failure("clock-enable count window never closed");
                    end
                    u_chk.check_value("cen6_count", a, u_chk.cen6_cnt);
                    u_chk.check_value("cen3_count", b, u_chk.cen3_cnt);
                    u_chk.check_value("cen1p5_count", e, u_chk.cen1p5_cnt);
                end
                default: u_chk.report_failure("unknown opcode in stimulus file");
            endcase
        end
        @(posedge clk);
        $display("checks %0d errors %0d", u_chk.chk_cnt, u_chk.err_cnt);
        if (u_chk.err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+hdl
hdl/kiwi_bus_pkg.sv
hdl/kiwi_cfg_pkg.sv
hdl/kiwi_frac_cen.sv
hdl/kiwi_dl_decode.sv
hdl/kiwi_cpu_port.sv
hdl/kiwi_shared_ram.sv
hdl/kiwi_shr_sys.sv
test/kiwi_shr_checker.sv
test/kiwi_shr_tb.sv

// File: test/kiwi_shr_stimulus.txt
// Columns, all hex: opcode, address or count, data, expected value
// 1/2 main wr/rd, 3/4 sub wr/rd, 5 dl byte, 6 prom byte, 7 mshramen, 8 burst, 9 cen counts
0009 0010 0008 0004
0001 0123 005a 0000
0004 0123 0000 005a
0003 0456 00c3 0000
0002 0456 0000 00c3
0001 0010 0011 0000
0007 0000 0000 0000
0002 0010 0000 00ff
0001 0010 0099 0000
0004 0010 0000 0011
0003 0020 0044 0000
0004 0020 0000 0044
0007 0001 0000 0000
0002 0020 0000 0044
0008 0006 0000 0000
0005 0004 0077 0000
0005 0004 000c 0003
0005 0004 0031 0002
0005 0005 0077 0002
0006 0000 00aa 0002
0006 03ff 00aa 0002
0006 0400 00aa 0000
0006 1fff 00aa 0000
0006 2000 00aa 0001
0006 ffff 00aa 0001
0000 0000 0000 0000
